// File: flist.f
+incdir+hdl
hdl/stream_pkg.sv
hdl/burst_ctrl.sv
hdl/pattern_gen.sv
hdl/axis_out_stage.sv
hdl/stream_master.sv
sim/stream_master_chk.sv
sim/stream_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module stream_master_tb -f flist.f -o stream_master_sim \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/stream_master_sim > sim.log 2>&1
cat sim.log

grep -qx "Test OK" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim/stream_master_tb.sv
`include "stream_cfg.svh"

module stream_master_tb
  import stream_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int START_COUNT  = `STREAM_START_COUNT;
  localparam int DATA_W       = `STREAM_DATA_W;
  localparam int LEN_W        = `STREAM_LEN_W;
  localparam int RESET_CYCLES = 5;
  localparam int RAND_BURSTS  = 20;
  localparam int NUM_BURSTS   = RAND_BURSTS + 5;

  logic              M_AXIS_ACLK;
  logic              M_AXIS_ARESETN;
  burst_cmd_t        cmd;
  logic              cmd_req;
  logic              cmd_ack;
  logic              m_axis_tvalid;
  logic [DATA_W-1:0] m_axis_tdata;
  logic              m_axis_tlast;
  logic              m_axis_tready;

  burst_cmd_t plan_cmd  [NUM_BURSTS];
  bit         plan_bp   [NUM_BURSTS]; // random tready while this burst runs
  int         plan_gap  [NUM_BURSTS];
  int         plan_hold [NUM_BURSTS]; // extra cycles cmd_req stays up after cmd_ack
  burst_cmd_t sent_q [$];
  bit         bp_mode;
  int         cycle_cnt;
  int         cycle_limit;
  bit         all_checked;

  stream_master uut (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cmd            (cmd),
    .cmd_req        (cmd_req),
    .cmd_ack        (cmd_ack),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tlast   (m_axis_tlast),
    .m_axis_tready  (m_axis_tready)
  );

  bind stream_master stream_master_chk chk (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cmd_req        (cmd_req),
    .cmd_ack        (cmd_ack),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tlast   (m_axis_tlast),
    .m_axis_tready  (m_axis_tready)
  );

  initial begin
    M_AXIS_ACLK = 1'b0;
    forever #50 M_AXIS_ACLK = ~M_AXIS_ACLK;
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // word k of a burst is one above base + k, wrapping at the word width
  function automatic logic [DATA_W-1:0] expected_word(input logic [DATA_W-1:0] base,
                                                      input int k);
    return base + DATA_W'(k + 1);
  endfunction

  task automatic check_beat(input axis_beat_t exp, input axis_beat_t act, input int k);
    if (act.data !== exp.data) begin
      fail_now($sformatf("[FAIL] %0d ns m_axis_tdata (beat %0d): expected 0x%08h, got 0x%08h",
                         $time, k, exp.data, act.data));
    end
    if (act.last !== exp.last) begin
      fail_now($sformatf("[FAIL] %0d ns m_axis_tlast (beat %0d): expected %b, got %b",
                         $time, k, exp.last, act.last));
    end
  endtask

  task automatic check_ack(input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("[FAIL] %0d ns cmd_ack: expected %b, got %b", $time, exp, act));
    end
  endtask

  task automatic check_valid(input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("[FAIL] %0d ns m_axis_tvalid: expected %b, got %b", $time, exp, act));
    end
  endtask

  task automatic check_delay(input int exp, input int act);
    if (act !== exp) begin
      fail_now($sformatf("[FAIL] %0d ns start delay of m_axis_tvalid: expected %0d, got %0d",
                         $time, exp, act));
    end
  endtask

  // old value of cycle_cnt is what every other posedge process reads
  always @(posedge M_AXIS_ACLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      fail_now($sformatf("timeout after %0d cycles, the DUT never finished its bursts",
                         cycle_cnt));
    end
  end

  always @(negedge M_AXIS_ACLK) begin
    if (bp_mode) begin
      m_axis_tready = ($urandom_range(0, 9) < 7);
    end else begin
      m_axis_tready = 1'b1;
    end
  end

  initial begin : main
    int total;
    void'($urandom(78));
    plan_cmd[0] = '{base: 32'h0000_0000, len: LEN_W'(8)};
    plan_cmd[1] = '{base: 32'hFFFF_FFFE, len: LEN_W'(4)};
    plan_cmd[2] = '{base: $urandom, len: LEN_W'(1)};
    plan_cmd[3] = '{base: $urandom, len: LEN_W'(1)};
    for (int i = 0; i < RAND_BURSTS; i++) begin
      plan_cmd[4 + i] = '{base: $urandom, len: LEN_W'($urandom_range(1, 16))};
    end
    plan_cmd[NUM_BURSTS - 1] = '{base: 32'hFFFF_FFF8, len: LEN_W'(16)};
    total = RESET_CYCLES + 2;
    for (int i = 0; i < NUM_BURSTS; i++) begin
      plan_bp[i]   = (i >= 3);
      plan_gap[i]  = $urandom_range(0, 2);
      plan_hold[i] = $urandom_range(0, 2);
      total += START_COUNT + 4 * int'(plan_cmd[i].len) + 10;
    end
    cycle_limit    = total;
    cycle_cnt      = 0;
    bp_mode        = 1'b0;
    M_AXIS_ARESETN = 1'b0;
    cmd            = '0;
    cmd_req        = 1'b0;
    m_axis_tready  = 1'b1;
    repeat (RESET_CYCLES) @(posedge M_AXIS_ACLK);
    @(negedge M_AXIS_ACLK);
    M_AXIS_ARESETN = 1'b1;

    // four-phase command driver
    for (int b = 0; b < NUM_BURSTS; b++) begin
      repeat (plan_gap[b]) @(negedge M_AXIS_ACLK);
      @(posedge M_AXIS_ACLK);
      bp_mode = plan_bp[b];
      @(negedge M_AXIS_ACLK);
      cmd = plan_cmd[b];
      sent_q.push_back(plan_cmd[b]);
      cmd_req = 1'b1;
      @(negedge M_AXIS_ACLK);
      while (cmd_ack !== 1'b1) begin
        @(negedge M_AXIS_ACLK);
      end
      repeat (plan_hold[b]) @(negedge M_AXIS_ACLK);
      cmd_req = 1'b0;
      @(negedge M_AXIS_ACLK);
      while (cmd_ack !== 1'b0) begin
        @(negedge M_AXIS_ACLK);
      end
    end
    wait (all_checked);
    @(negedge M_AXIS_ACLK);
    $display("Test OK");
    $finish;
  end

  initial begin : compare
    burst_cmd_t cur;
    axis_beat_t exp_beat;
    axis_beat_t got_beat;
    int         req_edge;
    int         k;
    bit         started;
    bit         prev_ready;
    all_checked = 1'b0;
    wait (M_AXIS_ARESETN === 1'b1);
    for (int b = 0; b < NUM_BURSTS; b++) begin
      do begin
        @(posedge M_AXIS_ACLK);
        check_ack(1'b0, cmd_ack);
        check_valid(1'b0, m_axis_tvalid); // nothing streams between bursts
      end while (cmd_req !== 1'b1);
      req_edge = cycle_cnt;
      if (sent_q.size() == 0) begin
        fail_now("cmd_req was raised but no command was recorded for it");
      end
      cur        = sent_q.pop_front();
      k          = 0;
      started    = 1'b0;
      prev_ready = 1'b0;
      while (k < int'(cur.len)) begin
        @(posedge M_AXIS_ACLK);
        check_ack(1'b0, cmd_ack);
        if (!started) begin
          if (m_axis_tvalid === 1'b1) begin
            // tvalid is set at an edge and first seen at the one after it
            check_delay(START_COUNT + 1, cycle_cnt - req_edge - 1);
            started = 1'b1;
          end
        end else if (prev_ready) begin
          check_valid(1'b1, m_axis_tvalid); // no bubble after an accepted cycle
        end
        if (m_axis_tvalid === 1'b1 && m_axis_tready === 1'b1) begin
          exp_beat.data = expected_word(cur.base, k);
          exp_beat.last = (k == int'(cur.len) - 1);
          got_beat.data = m_axis_tdata;
          got_beat.last = m_axis_tlast;
          check_beat(exp_beat, got_beat, k);
          k++;
        end
        prev_ready = m_axis_tready;
      end
      // the tlast handshake was at the edge just seen
      @(posedge M_AXIS_ACLK);
      check_ack(1'b1, cmd_ack);
      check_valid(1'b0, m_axis_tvalid);
      while (cmd_req === 1'b1) begin
        @(posedge M_AXIS_ACLK);
        check_ack(1'b1, cmd_ack);
      end
      @(posedge M_AXIS_ACLK);
      check_ack(1'b0, cmd_ack);
      check_valid(1'b0, m_axis_tvalid);
    end
    all_checked = 1'b1;
  end

endmodule

// File: sim/stream_master_chk.sv
`include "stream_cfg.svh"

module stream_master_chk (
  input logic                      M_AXIS_ACLK,
  input logic                      M_AXIS_ARESETN,
  input logic                      cmd_req,
  input logic                      cmd_ack,
  input logic                      m_axis_tvalid,
  input logic [`STREAM_DATA_W-1:0] m_axis_tdata,
  input logic                      m_axis_tlast,
  input logic                      m_axis_tready
);

  timeunit 1ns;
  timeprecision 100ps;

  // ack falls one cycle after req falls and stays low while nothing is requested
  ack_needs_req: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    !cmd_req |=> !cmd_ack
  ) else $error("cmd_ack is high although no cmd_req is pending");

  hold_under_backpressure: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    (m_axis_tvalid && !m_axis_tready)
      |=> (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
  ) else $error("beat changed or was dropped while m_axis_tready was low");

  valid_low_after_reset: assert property (
    @(posedge M_AXIS_ACLK)
    !M_AXIS_ARESETN |=> !m_axis_tvalid
  ) else $error("m_axis_tvalid is high right after reset");

  ack_low_after_reset: assert property (
    @(posedge M_AXIS_ACLK)
    !M_AXIS_ARESETN |=> !cmd_ack
  ) else $error("cmd_ack is high right after reset");

  // a burst never streams while its acknowledge is up
  no_beat_during_ack: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    cmd_ack |-> !m_axis_tvalid
  ) else $error("m_axis_tvalid is high while cmd_ack is high");

endmodule

// File: hdl/stream_master.sv
`include "stream_cfg.svh"

module stream_master
  import stream_pkg::*;
(
  input  logic                      M_AXIS_ACLK,
  input  logic                      M_AXIS_ARESETN,
  input  burst_cmd_t                cmd,
  input  logic                      cmd_req,
  output logic                      cmd_ack,
  output logic                      m_axis_tvalid,
  output logic [`STREAM_DATA_W-1:0] m_axis_tdata,
  output logic                      m_axis_tlast,
  input  logic                      m_axis_tready
);

  logic       load;
  logic       step;
  logic       gen_done;
  logic       in_ready;
  logic       last_sent;
  axis_beat_t beat;

  burst_ctrl u_ctrl (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cmd_req        (cmd_req),
    .in_ready       (in_ready),
    .gen_done       (gen_done),
    .last_sent      (last_sent),
    .cmd_ack        (cmd_ack),
    .load           (load),
    .step           (step)
  );

  pattern_gen u_gen (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cmd            (cmd),
    .load           (load),
    .step           (step),
    .beat           (beat),
    .done           (gen_done)
  );

  // step doubles as the valid of the beat being generated
  axis_out_stage u_out (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .in_beat        (beat),
    .in_valid       (step),
    .in_ready       (in_ready),
    .m_axis_tready  (m_axis_tready),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tlast   (m_axis_tlast),
    .last_sent      (last_sent)
  );

endmodule

// File: hdl/axis_out_stage.sv
`include "stream_cfg.svh"

module axis_out_stage
  import stream_pkg::*;
(
  input  logic                      M_AXIS_ACLK,
  input  logic                      M_AXIS_ARESETN,
  input  axis_beat_t                in_beat,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic                      m_axis_tready,
  output logic                      m_axis_tvalid,
  output logic [`STREAM_DATA_W-1:0] m_axis_tdata,
  output logic                      m_axis_tlast,
  output logic                      last_sent
);

  axis_beat_t beat_q;
  logic       valid_q;
  logic       accept;

  assign accept = valid_q && m_axis_tready; // the held beat completes its handshake

  // empty, or emptying in this cycle, so a new beat fits without a bubble
  assign in_ready = !valid_q || m_axis_tready;

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (in_ready && in_valid) begin
      beat_q <= in_beat; // untouched under back-pressure, so data and last stay stable
    end
  end

  assign m_axis_tvalid = valid_q;
  assign m_axis_tdata  = beat_q.data;
  assign m_axis_tlast  = beat_q.last;

  assign last_sent = accept && beat_q.last;

endmodule

// File: hdl/pattern_gen.sv
`include "stream_cfg.svh"

module pattern_gen
  import stream_pkg::*;
(
  input  logic       M_AXIS_ACLK,
  input  logic       M_AXIS_ARESETN,
  input  burst_cmd_t cmd,
  input  logic       load,
  input  logic       step,
  output axis_beat_t beat,
  output logic       done
);

  localparam int DATA_W = `STREAM_DATA_W;
  localparam int LEN_W  = `STREAM_LEN_W;

  burst_cmd_t       cmd_q;
  logic [LEN_W-1:0] idx;

  always_ff @(posedge M_AXIS_ACLK) begin
    if (load) begin
      cmd_q <= cmd; // base and len stay put for the whole burst
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      idx  <= '0;
      done <= 1'b0;
    end else if (load) begin
      idx  <= '0;
      done <= 1'b0;
    end else if (step) begin
      idx <= idx + 1'b1;
      if (beat.last) begin
        done <= 1'b1; // final beat has left, no more steps until the next load
      end
    end
  end

  // word k is base + k + 1, wrapping at the data width
  always_comb begin
    beat.data = cmd_q.base + DATA_W'(idx) + DATA_W'(1);
    beat.last = (idx == cmd_q.len - 1'b1);
  end

endmodule

// File: hdl/burst_ctrl.sv
`include "stream_cfg.svh"

module burst_ctrl (
  input  logic M_AXIS_ACLK,
  input  logic M_AXIS_ARESETN,
  input  logic cmd_req,
  input  logic in_ready,
  input  logic gen_done,
  input  logic last_sent,
  output logic cmd_ack,
  output logic load,
  output logic step
);

  localparam int START_COUNT = `STREAM_START_COUNT;
  localparam int CNT_W       = (START_COUNT > 1) ? $clog2(START_COUNT) : 1;

  typedef enum logic [1:0] {
    IDLE,
    DELAY,
    SEND,
    ACK
  } state_t;

  state_t           state;
  state_t           state_nxt;
  logic [CNT_W-1:0] delay_cnt;
  logic             delay_end;

  assign delay_end = (delay_cnt == CNT_W'(START_COUNT - 1)); // last idle cycle of the delay

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (cmd_req) begin
          state_nxt = DELAY;
        end
      end
      DELAY: begin
        if (delay_end) begin
          state_nxt = SEND;
        end
      end
      SEND: begin
        if (last_sent) begin // tlast accepted downstream, burst is complete
          state_nxt = ACK;
        end
      end
      ACK: begin
        if (!cmd_req) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // counts the cycles spent in DELAY and restarts from zero for every command
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      delay_cnt <= '0;
    end else if (state == DELAY) begin
      if (delay_end) begin
        delay_cnt <= '0;
      end else begin
        delay_cnt <= delay_cnt + 1'b1;
      end
    end else begin
      delay_cnt <= '0;
    end
  end

  // the command is captured at the same edge that leaves IDLE
  assign load = (state == IDLE) && cmd_req;

  // issue a beat whenever the output register can take one and beats remain
  assign step = (state == SEND) && in_ready && !gen_done;

  assign cmd_ack = (state == ACK); // held until the requester drops cmd_req

endmodule

// File: hdl/stream_pkg.sv
`include "stream_cfg.svh"

package stream_pkg;

  // one burst request as it is held on the req/ack handshake
  typedef struct packed {
    logic [`STREAM_DATA_W-1:0] base; // value one below the first word
    logic [`STREAM_LEN_W-1:0]  len;  // number of beats, never zero
  } burst_cmd_t;

  typedef struct packed {
    logic [`STREAM_DATA_W-1:0] data;
    logic                      last; // set on the final beat of a burst
  } axis_beat_t;

endpackage

// File: hdl/stream_cfg.svh
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// width of one word on the stream
`define STREAM_DATA_W 32

// beat count width, so a burst carries 1 to 255 beats
`define STREAM_LEN_W 8

// idle cycles between taking a command and issuing its first beat
`define STREAM_START_COUNT 32

`endif
